//--- sources.f
design/stackPkg.sv
design/alu.sv
design/executeDecode.sv
design/stackCache.sv
design/stackRam.sv
design/stackCore.sv
sim/tbClock.sv
sim/stackCore_sva.sv
sim/stackCoreTb.sv

//--- run.sh
#!/bin/sh
# Build and run the stack core testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f sources.f \
  --top-module stackCoreTb -Mdir obj_dir -o simStackCore
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

output=$(./obj_dir/simStackCore)
status=$?
printf '%s\n' "$output"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if printf '%s\n' "$output" | grep -qxF '*** PASSED ***'; then
  exit 0
fi
exit 1

//--- sim/stackCoreTb.sv
`timescale 1ns/1ns
`default_nettype none

module stackCoreTb import stackPkg::*;;

  localparam int dataBits          = 16;
  localparam int addrBits          = 6;
  localparam int resetStackPointer = 40;
  localparam int readyTimeout      = 20;
  localparam int modePush          = 0;
  localparam int modeDrain         = 1;
  localparam int modeMixed         = 2;
  localparam int modeErrors        = 3;

  logic                 clk;
  logic                 arstN;
  logic                 instrValid;
  logic [7:0]           instruction;
  logic                 instrReady;
  logic [dataBits-1:0]  topOfStack1;
  logic [dataBits-1:0]  topOfStack2;
  logic [dataBits-1:0]  topOfStack3;
  logic [addrBits-1:0]  stackPointer;
  logic [3:0]           aluFlags;
  logic                 decodeError;

  // Reference model, index 0 is the bottom of the stack
  logic [15:0] modelStack [0:63];
  int          depth;
  logic [3:0]  modelFlags;
  logic        modelBad;
  integer      seed;
  logic        timedOut;
  int          checkCount;
  int          errorCount;
  int          testErrorBase;

  tbClock #(.periodNs(10), .resetCycles(2)) clockGen (.clk(clk), .arstN(arstN));

  stackCore #(
    .dataBits         (dataBits),
    .addrBits         (addrBits),
    .resetStackPointer(resetStackPointer)
  ) uut (
    .clk         (clk),
    .arstN       (arstN),
    .instrValid  (instrValid),
    .instruction (instruction),
    .instrReady  (instrReady),
    .topOfStack1 (topOfStack1),
    .topOfStack2 (topOfStack2),
    .topOfStack3 (topOfStack3),
    .stackPointer(stackPointer),
    .aluFlags    (aluFlags),
    .decodeError (decodeError)
  );

  task automatic compareValue(input string name, input logic [31:0] actual,
                              input logic [31:0] expected);
    checkCount++;
    if (actual !== expected)
    begin
      errorCount++;
      $display("[FAIL] %s: got 0x%0h, expected 0x%0h", name, actual, expected);
    end
  endtask

  task automatic checkState();
    compareValue("topOfStack1", 32'(topOfStack1), 32'(modelStack[depth-1]));
    compareValue("topOfStack2", 32'(topOfStack2), 32'(modelStack[depth-2]));
    compareValue("topOfStack3", 32'(topOfStack3), 32'(modelStack[depth-3]));
    compareValue("stackPointer", 32'(stackPointer), resetStackPointer + 3 - depth);
    compareValue("aluFlags", 32'(aluFlags), 32'(modelFlags));
    compareValue("decodeError", 32'(decodeError), 32'(modelBad));
  endtask

  // A is element 2 and B is element 1, shift amount is the low nibble of B
  task automatic modelAlu(input logic [3:0] func, input logic [15:0] a, input logic [15:0] b,
                          output logic [15:0] result, output logic [3:0] flags);
    int   amount;
    int   wide;
    int   signedWide;
    logic carry;
    logic overflow;
    amount   = int'(b[3:0]);
    carry    = 1'b0;
    overflow = 1'b0;
    result   = '0;
    case (func)
      aluAdd:
      begin
        wide       = int'(a) + int'(b);
        signedWide = int'($signed(a)) + int'($signed(b));
        result     = wide[15:0];
        carry      = wide > 65535;
        overflow   = (signedWide > 32767) || (signedWide < -32768);
      end
      aluSub, aluCompare:
      begin
        wide       = int'(a) - int'(b);
        signedWide = int'($signed(a)) - int'($signed(b));
        result     = wide[15:0];
        carry      = a < b;
        overflow   = (signedWide > 32767) || (signedWide < -32768);
      end
      aluAnd, aluTest:
        result = a & b;
      aluOr:
        result = a | b;
      aluXor:
        result = a ^ b;
      aluNot:
        result = ~b;
      aluShl:
      begin
        result = a << amount;
        carry  = (amount != 0) && a[16 - amount];
      end
      aluShr:
      begin
        result = a >> amount;
        carry  = (amount != 0) && a[amount - 1];
      end
      default:
        result = '0;
    endcase
    flags               = '0;
    flags[flagZero]     = (result == 16'h0);
    flags[flagNegative] = result[15];
    flags[flagCarry]    = carry;
    flags[flagOverflow] = overflow;
  endtask

  task automatic applyModel(input logic [7:0] instr);
    logic [3:0]  op;
    logic [3:0]  arg;
    logic [15:0] e1;
    logic [15:0] e2;
    logic [15:0] e3;
    logic [15:0] res;
    logic [3:0]  fl;
    op       = instr[7:4];
    arg      = instr[3:0];
    e1       = modelStack[depth-1];
    e2       = modelStack[depth-2];
    e3       = modelStack[depth-3];
    modelBad = 1'b0;
    case (op)
      opAlu:
        if (arg <= aluTest)
        begin
          modelAlu(arg, e2, e1, res, fl);
          modelFlags = fl;
          if (arg == aluNot)
            modelStack[depth-1] = res;
          else if (arg == aluCompare || arg == aluTest)
            depth -= 2;
          else
          begin
            depth--;
            modelStack[depth-1] = res;
          end
        end
        else
          modelBad = 1'b1;
      opPush:
      begin
        modelStack[depth] = {12'h0, arg};
        depth++;
      end
      // Flags untouched
      opAddSmall:
        modelStack[depth-1] = e1 + {12'h0, arg};
      opStack:
        case (arg)
          stackDrop:
            depth--;
          stackDup:
          begin
            modelStack[depth] = e1;
            depth++;
          end
          stackRot:
          begin
            modelStack[depth-1] = e2;
            modelStack[depth-2] = e3;
            modelStack[depth-3] = e1;
          end
          stackSwap:
          begin
            modelStack[depth-1] = e2;
            modelStack[depth-2] = e1;
          end
          stackTuck:
          begin
            modelStack[depth-1] = e3;
            modelStack[depth-2] = e1;
            modelStack[depth-3] = e2;
          end
          default:
            modelBad = 1'b1;
        endcase
      default:
        modelBad = 1'b1;
    endcase
  endtask

  // Keeps the depth between 3 and resetStackPointer + 3
  function automatic bit isLegal(input logic [7:0] instr);
    logic [3:0] op;
    logic [3:0] arg;
    op  = instr[7:4];
    arg = instr[3:0];
    if (op == opPush || (op == opStack && arg == stackDup))
      return depth < resetStackPointer + 3;
    if (op == opStack && arg == stackDrop)
      return depth >= 4;
    if (op == opAlu && (arg == aluCompare || arg == aluTest))
      return depth >= 5;
    if (op == opAlu && arg != aluNot)
      return depth >= 4;
    return 1'b1;
  endfunction

  function automatic logic [7:0] nextInstr(input int mode);
    logic [31:0] r;
    logic [31:0] pick;
    logic [7:0]  instr;
    r    = $random(seed);
    pick = $random(seed);
    if (mode == modeErrors && !modelBad)
    begin
      case (r % 3)
        0: instr = {4'(4 + pick % 12), pick[7:4]};
        1: instr = {opAlu, 4'(10 + pick % 6)};
        default: instr = {opStack, 4'(5 + pick % 11)};
      endcase
    end
    else if (mode == modePush)
      instr = {opPush, r[3:0]};
    else if (mode == modeDrain)
      instr = (depth >= 5 && r[0]) ? {opAlu, aluCompare} : {opStack, stackDrop};
    else
    begin
      case (r % 4)
        0: instr = {opAlu, 4'(pick % 10)};
        1: instr = {opPush, pick[3:0]};
        2: instr = {opAddSmall, pick[3:0]};
        default: instr = {opStack, 4'(pick % 5)};
      endcase
      if (!isLegal(instr))
        instr = {opStack, stackSwap};
    end
    return instr;
  endfunction

  // Called at a falling edge, returns the number of low cycles seen
  task automatic waitReady(input string what, output int cycles);
    cycles = 0;
    while (!instrReady && cycles < readyTimeout)
    begin
      @(negedge clk);
      cycles++;
    end
    if (!instrReady && !timedOut)
    begin
      timedOut = 1'b1;
      $display("Timeout: instrReady stayed low while waiting for %s", what);
    end
  endtask

  task automatic runStream(input int count, input int mode, input bit hold);
    logic [7:0] instr;
    int         i;
    int         lowCycles;
    for (i = 0; i < count && !timedOut; i++)
    begin
      if (!hold || i == 0)
      begin
        instr = nextInstr(mode);
        @(posedge clk);
        instrValid  <= 1'b1;
        instruction <= instr;
        @(negedge clk);
      end
      waitReady("accept", lowCycles);
      if (!timedOut)
      begin
        // Accept edge
        @(posedge clk);
        applyModel(instr);
        if (hold && i < count - 1)
        begin
          instr = nextInstr(mode);
          instruction <= instr;
        end
        else
          instrValid <= 1'b0;
        @(negedge clk);
        waitReady("completion", lowCycles);
        if (hold)
          compareValue("instrReady low cycles", lowCycles, 1);
        checkState();
      end
    end
  endtask

  task automatic reportTest(input string name);
    $display("[DONE] %s: %0d errors", name, errorCount - testErrorBase);
    testErrorBase = errorCount;
  endtask

  initial
  begin
    int waitCount;
    seed          = 3;
    depth         = 3;
    modelFlags    = '0;
    modelBad      = 1'b0;
    timedOut      = 1'b0;
    checkCount    = 0;
    errorCount    = 0;
    testErrorBase = 0;
    instrValid    = 1'b0;
    instruction   = '0;
    for (int k = 0; k < 64; k++)
      modelStack[k] = '0;

    waitCount = 0;
    while (arstN !== 1'b1 && waitCount < 10)
    begin
      @(negedge clk);
      waitCount++;
    end
    if (arstN !== 1'b1)
    begin
      timedOut = 1'b1;
      $display("Timeout: reset was never released");
    end

    checkState();
    compareValue("instrReady", 32'(instrReady), 1);
    reportTest("reset state");

    runStream(30, modePush, 1'b0);
    reportTest("pushes with spill");

    // Each step removes one or two words, so this ends
    while (depth > 3 && !timedOut)
      runStream(1, modeDrain, 1'b0);
    reportTest("drops and refill");

    runStream(300, modeMixed, 1'b0);
    reportTest("mixed random stream");

    runStream(40, modeErrors, 1'b0);
    reportTest("decode errors");

    runStream(40, modeMixed, 1'b1);
    reportTest("two-cycle handshake");

    $display("Checks: %0d, errors: %0d, timeout: %0d", checkCount, errorCount, timedOut);
    if (errorCount == 0 && !timedOut)
      $display("*** PASSED ***");
    else
      $display("*** FAILED ***");
    $finish;
  end

endmodule

`default_nettype wire

//--- sim/stackCore_sva.sv
`timescale 1ns/1ns
`default_nettype none

module stackCoreSva import stackPkg::*; (
  input logic   clk,
  input logic   arstN,
  input logic   issue,
  input logic   instrReady,
  input logic   writeEnable,
  input logic   badInstr,
  input refillT refill,
  input phaseT  phase
);

  // Every accept is followed by exactly one refill cycle
  issueThenRefill: assert property (@(posedge clk) disable iff (!arstN)
    issue |=> (phase == phaseRefill) && !instrReady)
    else $error("issue not followed by refill phase with instrReady low");

  // The refill phase lasts one cycle and readiness returns after it
  refillThenIssue: assert property (@(posedge clk) disable iff (!arstN)
    (phase == phaseRefill) |=> (phase == phaseIssue) && instrReady)
    else $error("refill phase not followed by issue phase with instrReady high");

  // A spill never shares an instruction with a refill or a decode error
  writeWithoutRefill: assert property (@(posedge clk) disable iff (!arstN)
    writeEnable |-> (refill == refillNone) && !badInstr)
    else $error("RAM write enable together with a refill or a bad instruction");

endmodule

bind stackCache stackCoreSva sva (
  .clk        (clk),
  .arstN      (arstN),
  .issue      (issue),
  .instrReady (instrReady),
  .writeEnable(writeEnable),
  .badInstr   (badInstr),
  .refill     (refill),
  .phase      (phase)
);

`default_nettype wire

//--- sim/tbClock.sv
`timescale 1ns/1ns
`default_nettype none

module tbClock #(
  parameter int periodNs    = 10,
  parameter int resetCycles = 2
) (
  output logic clk,
  output logic arstN
);

  initial
  begin
    clk = 1'b0;
    forever #(periodNs / 2) clk = ~clk;
  end

  // Reset released on a rising edge after resetCycles edges
  initial
  begin
    arstN = 1'b0;
    repeat (resetCycles) @(posedge clk);
    arstN <= 1'b1;
  end

endmodule

`default_nettype wire

//--- design/stackCore.sv
`timescale 1ns/1ns
`default_nettype none

module stackCore import stackPkg::*; #(
  parameter int dataBits          = 16,
  parameter int addrBits          = 6,
  parameter int resetStackPointer = 40
) (
  input  logic                 clk,
  input  logic                 arstN,
  input  logic                 instrValid,
  input  logic [instrBits-1:0] instruction,
  output logic                 instrReady,
  output logic [dataBits-1:0]  topOfStack1,
  output logic [dataBits-1:0]  topOfStack2,
  output logic [dataBits-1:0]  topOfStack3,
  output logic [addrBits-1:0]  stackPointer,
  output logic [flagCount-1:0] aluFlags,
  output logic                 decodeError
);

  logic [dataBits-1:0] nextTop1;
  logic [dataBits-1:0] nextTop2;
  logic [dataBits-1:0] nextTop3;
  logic [addrBits-1:0] nextStackPointer;
  logic                ramWrite;
  logic                writeEnable;
  logic [addrBits-1:0] writeAddr;
  logic [dataBits-1:0] writeData;
  logic [addrBits-1:0] readAddrA;
  logic [addrBits-1:0] readAddrB;
  logic [dataBits-1:0] readDataA;
  logic [dataBits-1:0] readDataB;
  refillT              refill;
  aluFuncT             aluFunc;
  logic [dataBits-1:0] aluA;
  logic [dataBits-1:0] aluB;
  logic [dataBits-1:0] aluResult;
  logic                updateFlags;
  logic                badInstr;
  logic                issue;

  executeDecode #(
    .dataBits(dataBits),
    .addrBits(addrBits)
  ) decode (
    .instruction     (instruction),
    .topOfStack1     (topOfStack1),
    .topOfStack2     (topOfStack2),
    .topOfStack3     (topOfStack3),
    .stackPointer    (stackPointer),
    .aluResult       (aluResult),
    .nextTop1        (nextTop1),
    .nextTop2        (nextTop2),
    .nextTop3        (nextTop3),
    .nextStackPointer(nextStackPointer),
    .ramWrite        (ramWrite),
    .writeAddr       (writeAddr),
    .writeData       (writeData),
    .readAddrA       (readAddrA),
    .readAddrB       (readAddrB),
    .refill          (refill),
    .aluFunc         (aluFunc),
    .aluA            (aluA),
    .aluB            (aluB),
    .updateFlags     (updateFlags),
    .badInstr        (badInstr)
  );

  alu #(
    .dataBits(dataBits)
  ) alu0 (
    .clk        (clk),
    .arstN      (arstN),
    .issue      (issue),
    .aluFunc    (aluFunc),
    .aluA       (aluA),
    .aluB       (aluB),
    .updateFlags(updateFlags),
    .aluResult  (aluResult),
    .aluFlags   (aluFlags)
  );

  stackCache #(
    .dataBits         (dataBits),
    .addrBits         (addrBits),
    .resetStackPointer(resetStackPointer)
  ) cache (
    .clk             (clk),
    .arstN           (arstN),
    .instrValid      (instrValid),
    .nextTop1        (nextTop1),
    .nextTop2        (nextTop2),
    .nextTop3        (nextTop3),
    .nextStackPointer(nextStackPointer),
    .refill          (refill),
    .ramWrite        (ramWrite),
    .badInstr        (badInstr),
    .readDataA       (readDataA),
    .readDataB       (readDataB),
    .instrReady      (instrReady),
    .issue           (issue),
    .writeEnable     (writeEnable),
    .topOfStack1     (topOfStack1),
    .topOfStack2     (topOfStack2),
    .topOfStack3     (topOfStack3),
    .stackPointer    (stackPointer),
    .decodeError     (decodeError)
  );

  stackRam #(
    .dataBits(dataBits),
    .addrBits(addrBits)
  ) ram (
    .clk        (clk),
    .writeEnable(writeEnable),
    .writeAddr  (writeAddr),
    .writeData  (writeData),
    .readAddrA  (readAddrA),
    .readAddrB  (readAddrB),
    .readDataA  (readDataA),
    .readDataB  (readDataB)
  );

endmodule

`default_nettype wire

//--- design/stackRam.sv
`timescale 1ns/1ns
`default_nettype none

module stackRam #(
  parameter int dataBits = 16,
  parameter int addrBits = 6
) (
  input  logic                clk,
  input  logic                writeEnable,
  input  logic [addrBits-1:0] writeAddr,
  input  logic [dataBits-1:0] writeData,
  input  logic [addrBits-1:0] readAddrA,
  input  logic [addrBits-1:0] readAddrB,
  output logic [dataBits-1:0] readDataA,
  output logic [dataBits-1:0] readDataB
);

  logic [dataBits-1:0] mem [2**addrBits];

  always_ff @(posedge clk)
  begin
    if (writeEnable)
      mem[writeAddr] <= writeData;
    // Both read ports registered
    readDataA <= mem[readAddrA];
    readDataB <= mem[readAddrB];
  end

endmodule

`default_nettype wire

//--- design/stackCache.sv
`timescale 1ns/1ns
`default_nettype none

module stackCache import stackPkg::*; #(
  parameter int dataBits          = 16,
  parameter int addrBits          = 6,
  parameter int resetStackPointer = 40
) (
  input  logic                clk,
  input  logic                arstN,
  input  logic                instrValid,
  input  logic [dataBits-1:0] nextTop1,
  input  logic [dataBits-1:0] nextTop2,
  input  logic [dataBits-1:0] nextTop3,
  input  logic [addrBits-1:0] nextStackPointer,
  input  refillT              refill,
  input  logic                ramWrite,
  input  logic                badInstr,
  input  logic [dataBits-1:0] readDataA,
  input  logic [dataBits-1:0] readDataB,
  output logic                instrReady,
  output logic                issue,
  output logic                writeEnable,
  output logic [dataBits-1:0] topOfStack1,
  output logic [dataBits-1:0] topOfStack2,
  output logic [dataBits-1:0] topOfStack3,
  output logic [addrBits-1:0] stackPointer,
  output logic                decodeError
);

  phaseT  phase;
  refillT pendingRefill;

  // Accept only in the issue phase
  assign instrReady  = (phase == phaseIssue);
  assign issue       = instrValid && instrReady;
  assign writeEnable = ramWrite && issue;

  always_ff @(posedge clk or negedge arstN)
  begin
    if (!arstN)
    begin
      phase         <= phaseIssue;
      pendingRefill <= refillNone;
      topOfStack1   <= '0;
      topOfStack2   <= '0;
      topOfStack3   <= '0;
      stackPointer  <= addrBits'(resetStackPointer);
      decodeError   <= 1'b0;
    end
    else if (issue)
    begin
      phase         <= phaseRefill;
      pendingRefill <= refill;
      topOfStack1   <= nextTop1;
      topOfStack2   <= nextTop2;
      topOfStack3   <= nextTop3;
      stackPointer  <= nextStackPointer;
      decodeError   <= badInstr;
    end
    else if (phase == phaseRefill)
    begin
      phase <= phaseIssue;
      // RAM data was addressed on the issue edge
      if (pendingRefill == refillS3)
        topOfStack3 <= readDataA;
      else if (pendingRefill == refillS2S3)
      begin
        topOfStack2 <= readDataA;
        topOfStack3 <= readDataB;
      end
    end
  end

endmodule

`default_nettype wire

//--- design/executeDecode.sv
`timescale 1ns/1ns
`default_nettype none

module executeDecode import stackPkg::*; #(
  parameter int dataBits = 16,
  parameter int addrBits = 6
) (
  input  logic [instrBits-1:0] instruction,
  input  logic [dataBits-1:0]  topOfStack1,
  input  logic [dataBits-1:0]  topOfStack2,
  input  logic [dataBits-1:0]  topOfStack3,
  input  logic [addrBits-1:0]  stackPointer,
  input  logic [dataBits-1:0]  aluResult,
  output logic [dataBits-1:0]  nextTop1,
  output logic [dataBits-1:0]  nextTop2,
  output logic [dataBits-1:0]  nextTop3,
  output logic [addrBits-1:0]  nextStackPointer,
  output logic                 ramWrite,
  output logic [addrBits-1:0]  writeAddr,
  output logic [dataBits-1:0]  writeData,
  output logic [addrBits-1:0]  readAddrA,
  output logic [addrBits-1:0]  readAddrB,
  output refillT               refill,
  output aluFuncT              aluFunc,
  output logic [dataBits-1:0]  aluA,
  output logic [dataBits-1:0]  aluB,
  output logic                 updateFlags,
  output logic                 badInstr
);

  opcodeT              opcode;
  aluFuncT             aluOp;
  stackOpT             stackOp;
  logic [3:0]          operand;
  logic [dataBits-1:0] operandWord;
  logic                pop1;
  logic                pop2;
  logic                write3;

  assign opcode      = opcodeT'(instruction[7:4]);
  assign operand     = instruction[3:0];
  assign aluOp       = aluFuncT'(operand);
  assign stackOp     = stackOpT'(operand);
  assign operandWord = {{(dataBits-4){1'b0}}, operand};

  // Old element 3 spills to sp+2; refills come from sp+3 and sp+4
  assign writeAddr = stackPointer + addrBits'(2);
  assign writeData = topOfStack3;
  assign readAddrA = stackPointer + addrBits'(3);
  assign readAddrB = stackPointer + addrBits'(4);

  always_comb
  begin
    nextTop1         = topOfStack1;
    nextTop2         = topOfStack2;
    nextTop3         = topOfStack3;
    nextStackPointer = stackPointer;
    ramWrite         = 1'b0;
    refill           = refillNone;
    aluFunc          = aluAdd;
    aluA             = topOfStack2;
    aluB             = topOfStack1;
    updateFlags      = 1'b0;
    badInstr         = 1'b0;
    pop1             = 1'b0;
    pop2             = 1'b0;
    write3           = 1'b0;

    case (opcode)
      opAlu:
      begin
        aluFunc = aluOp;
        case (aluOp)
          aluAdd, aluSub, aluAnd, aluOr, aluXor, aluShl, aluShr:
          begin
            updateFlags = 1'b1;
            nextTop1    = aluResult;
            pop1        = 1'b1;
          end
          aluNot:
          begin
            updateFlags = 1'b1;
            nextTop1    = aluResult;
          end
          // Flags only, both operands leave the stack
          aluCompare, aluTest:
          begin
            updateFlags = 1'b1;
            pop2        = 1'b1;
          end
          default:
            badInstr = 1'b1;
        endcase
      end
      opPush:
      begin
        nextTop1 = operandWord;
        nextTop2 = topOfStack1;
        nextTop3 = topOfStack2;
        write3   = 1'b1;
      end
      opAddSmall:
      begin
        aluA     = topOfStack1;
        aluB     = operandWord;
        nextTop1 = aluResult;
      end
      opStack:
      begin
        case (stackOp)
          stackDrop:
          begin
            nextTop1 = topOfStack2;
            pop1     = 1'b1;
          end
          stackDup:
          begin
            nextTop2 = topOfStack1;
            nextTop3 = topOfStack2;
            write3   = 1'b1;
          end
          stackRot:
          begin
            nextTop1 = topOfStack2;
            nextTop2 = topOfStack3;
            nextTop3 = topOfStack1;
          end
          stackSwap:
          begin
            nextTop1 = topOfStack2;
            nextTop2 = topOfStack1;
          end
          stackTuck:
          begin
            nextTop1 = topOfStack3;
            nextTop2 = topOfStack1;
            nextTop3 = topOfStack2;
          end
          default:
            badInstr = 1'b1;
        endcase
      end
      default:
        badInstr = 1'b1;
    endcase

    // Shared spill and refill steps
    if (pop1)
    begin
      nextTop2         = topOfStack3;
      nextStackPointer = stackPointer + addrBits'(1);
      refill           = refillS3;
    end
    else if (pop2)
    begin
      nextTop1         = topOfStack3;
      nextStackPointer = stackPointer + addrBits'(2);
      refill           = refillS2S3;
    end
    else if (write3)
    begin
      ramWrite         = 1'b1;
      nextStackPointer = stackPointer - addrBits'(1);
    end
  end

endmodule

`default_nettype wire

//--- design/alu.sv
`timescale 1ns/1ns
`default_nettype none

module alu import stackPkg::*; #(
  parameter int dataBits = 16
) (
  input  logic                 clk,
  input  logic                 arstN,
  input  logic                 issue,
  input  aluFuncT              aluFunc,
  input  logic [dataBits-1:0]  aluA,
  input  logic [dataBits-1:0]  aluB,
  input  logic                 updateFlags,
  output logic [dataBits-1:0]  aluResult,
  output logic [flagCount-1:0] aluFlags
);

  localparam int shiftBits = $clog2(dataBits);

  logic [dataBits:0]    sum;
  logic [dataBits:0]    diff;
  logic [dataBits:0]    shlWide;
  logic [dataBits:0]    shrWide;
  logic [shiftBits-1:0] shiftAmount;
  logic                 carry;
  logic                 overflow;
  logic [flagCount-1:0] nextFlags;

  assign shiftAmount = aluB[shiftBits-1:0];
  assign sum         = {1'b0, aluA} + {1'b0, aluB};
  // Top bit of diff is the borrow
  assign diff        = {1'b0, aluA} - {1'b0, aluB};
  // Extra bit catches the last bit shifted out
  assign shlWide     = {1'b0, aluA} << shiftAmount;
  assign shrWide     = {aluA, 1'b0} >> shiftAmount;

  always_comb
  begin
    aluResult = '0;
    carry     = 1'b0;
    overflow  = 1'b0;
    case (aluFunc)
      aluAdd:
      begin
        aluResult = sum[dataBits-1:0];
        carry     = sum[dataBits];
        overflow  = (aluA[dataBits-1] == aluB[dataBits-1]) &&
                    (sum[dataBits-1] != aluA[dataBits-1]);
      end
      // Compare keeps the difference only for the flags
      aluSub, aluCompare:
      begin
        aluResult = diff[dataBits-1:0];
        carry     = diff[dataBits];
        overflow  = (aluA[dataBits-1] != aluB[dataBits-1]) &&
                    (diff[dataBits-1] != aluA[dataBits-1]);
      end
      aluAnd, aluTest:
        aluResult = aluA & aluB;
      aluOr:
        aluResult = aluA | aluB;
      aluXor:
        aluResult = aluA ^ aluB;
      aluNot:
        aluResult = ~aluB;
      aluShl:
      begin
        aluResult = shlWide[dataBits-1:0];
        carry     = shlWide[dataBits];
      end
      aluShr:
      begin
        aluResult = shrWide[dataBits:1];
        carry     = shrWide[0];
      end
      default:
        aluResult = '0;
    endcase
  end

  always_comb
  begin
    nextFlags               = '0;
    nextFlags[flagZero]     = (aluResult == '0);
    nextFlags[flagNegative] = aluResult[dataBits-1];
    nextFlags[flagCarry]    = carry;
    nextFlags[flagOverflow] = overflow;
  end

  always_ff @(posedge clk or negedge arstN)
  begin
    if (!arstN)
      aluFlags <= '0;
    else if (issue && updateFlags)
      aluFlags <= nextFlags;
  end

endmodule

`default_nettype wire

//--- design/stackPkg.sv
`default_nettype none

package stackPkg;

  // Instruction byte layout
  localparam int instrBits = 8;
  localparam int flagCount = 4;

  // Flag bit positions in the flags word
  localparam int flagZero     = 0;
  localparam int flagNegative = 1;
  localparam int flagCarry    = 2;
  localparam int flagOverflow = 3;

  // Upper nibble of the instruction
  typedef enum logic [3:0] {
    opAlu      = 4'd0,
    opPush     = 4'd1,
    opAddSmall = 4'd2,
    opStack    = 4'd3
  } opcodeT;

  // Lower nibble under opAlu
  typedef enum logic [3:0] {
    aluAdd     = 4'd0,
    aluSub     = 4'd1,
    aluAnd     = 4'd2,
    aluOr      = 4'd3,
    aluXor     = 4'd4,
    aluNot     = 4'd5,
    aluShl     = 4'd6,
    aluShr     = 4'd7,
    aluCompare = 4'd8,
    aluTest    = 4'd9
  } aluFuncT;

  // Lower nibble under opStack
  typedef enum logic [3:0] {
    stackDrop = 4'd0,
    stackDup  = 4'd1,
    stackRot  = 4'd2,
    stackSwap = 4'd3,
    stackTuck = 4'd4
  } stackOpT;

  // Registers reloaded from RAM in the second cycle
  typedef enum logic [1:0] {
    refillNone,
    refillS3,
    refillS2S3
  } refillT;

  typedef enum logic {
    phaseIssue,
    phaseRefill
  } phaseT;

endpackage

`default_nettype wire
